/* rtl/vdp_pkg.sv */
package vdp_pkg;

  // datapath and bus widths
  localparam int data_width_c     = 64;
  localparam int addr_width_c     = 32;
  localparam int max_len_c        = 8;
  localparam int elem_bytes_c     = 8;
  localparam int csr_addr_width_c = 3;

  // register map
  localparam logic [csr_addr_width_c-1:0] csr_a_ptr_c   = 3'd0;
  localparam logic [csr_addr_width_c-1:0] csr_b_ptr_c   = 3'd1;
  localparam logic [csr_addr_width_c-1:0] csr_len_c     = 3'd2;
  localparam logic [csr_addr_width_c-1:0] csr_start_c   = 3'd3;
  localparam logic [csr_addr_width_c-1:0] csr_status_c  = 3'd4;
  localparam logic [csr_addr_width_c-1:0] csr_res_ptr_c = 3'd5;

  // sequencer states
  // load phase walks A then B, store phase writes the sum
  typedef enum logic [2:0] {
    IDLE,
    LOAD_REQ,
    LOAD_WAIT,
    STORE_REQ,
    STORE_WAIT,
    FINISH
  } vdp_state_e;

endpackage

/* rtl/vdp_csr.sv */
`timescale 1ns/1ps

module vdp_csr (
  input  logic                                  clk_i
  , input  logic                                reset_i

  , input  logic                                csr_v_i
  , input  logic                                csr_we_i
  , input  logic [vdp_pkg::csr_addr_width_c-1:0] csr_addr_i
  , input  logic [vdp_pkg::data_width_c-1:0]     csr_wdata_i

  , input  logic                                idle_i
  , input  logic                                done_i

  , output logic                                csr_resp_v_o
  , output logic [vdp_pkg::data_width_c-1:0]     csr_rdata_o

  , output logic                                start_o
  , output logic [vdp_pkg::data_width_c-1:0]     a_ptr_o
  , output logic [vdp_pkg::data_width_c-1:0]     b_ptr_o
  , output logic [vdp_pkg::data_width_c-1:0]     len_o
  , output logic [vdp_pkg::data_width_c-1:0]     res_ptr_o
);

  import vdp_pkg::*;

  logic [data_width_c-1:0] a_ptr_r;
  logic [data_width_c-1:0] b_ptr_r;
  logic [data_width_c-1:0] len_r;
  logic [data_width_c-1:0] start_r;
  logic [data_width_c-1:0] res_ptr_r;
  logic [data_width_c-1:0] rd_val;

  // command registers, cleared when a job completes
  always_ff @(posedge clk_i) begin
    if (reset_i || done_i) begin
      a_ptr_r   <= '0;
      b_ptr_r   <= '0;
      len_r     <= '0;
      start_r   <= '0;
      res_ptr_r <= '0;
    end else if (csr_v_i && csr_we_i) begin
      case (csr_addr_i)
        csr_a_ptr_c:   a_ptr_r   <= csr_wdata_i;
        csr_b_ptr_c:   b_ptr_r   <= csr_wdata_i;
        csr_len_c:     len_r     <= csr_wdata_i;
        csr_start_c:   start_r   <= csr_wdata_i;
        csr_res_ptr_c: res_ptr_r <= csr_wdata_i;
        default: begin
        end
      endcase
    end
  end

  // status is read only and comes straight from the sequencer
  always_comb begin
    case (csr_addr_i)
      csr_a_ptr_c:   rd_val = a_ptr_r;
      csr_b_ptr_c:   rd_val = b_ptr_r;
      csr_len_c:     rd_val = len_r;
      csr_start_c:   rd_val = start_r;
      csr_status_c:  rd_val = {{(data_width_c-1){1'b0}}, idle_i};
      csr_res_ptr_c: rd_val = res_ptr_r;
      default:       rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      csr_resp_v_o <= 1'b0;
    end else begin
      csr_resp_v_o <= csr_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (csr_v_i && !csr_we_i) begin
      csr_rdata_o <= rd_val;
    end
  end

  assign start_o   = |start_r;
  assign a_ptr_o   = a_ptr_r;
  assign b_ptr_o   = b_ptr_r;
  assign len_o     = len_r;
  assign res_ptr_o = res_ptr_r;

endmodule

/* rtl/vdp_sequencer.sv */
`timescale 1ns/1ps

module vdp_sequencer #(
  parameter int data_width_p = vdp_pkg::data_width_c
  , parameter int addr_width_p = vdp_pkg::addr_width_c
  , parameter int max_len_p    = vdp_pkg::max_len_c
) (
  input  logic                                clk_i
  , input  logic                              reset_i

  , input  logic                              start_i
  , input  logic [vdp_pkg::data_width_c-1:0]   a_ptr_i
  , input  logic [vdp_pkg::data_width_c-1:0]   b_ptr_i
  , input  logic [vdp_pkg::data_width_c-1:0]   len_i
  , input  logic [vdp_pkg::data_width_c-1:0]   res_ptr_i
  , input  logic [data_width_p-1:0]           dot_i

  , output logic                              idle_o
  , output logic                              done_o

  , output logic                              clear_o
  , output logic                              wr_a_o
  , output logic                              wr_b_o
  , output logic [$clog2(max_len_p)-1:0]      idx_o
  , output logic [data_width_p-1:0]           load_data_o

  , output logic                              mem_req_v_o
  , output logic                              mem_req_we_o
  , output logic [addr_width_p-1:0]           mem_req_addr_o
  , output logic [data_width_p-1:0]           mem_req_wdata_o
  , input  logic                              mem_req_ready_i
  , input  logic                              mem_resp_v_i
  , input  logic [data_width_p-1:0]           mem_resp_data_i
);

  import vdp_pkg::*;

  localparam int idx_width_lp = $clog2(max_len_p);

  vdp_state_e state_r;
  vdp_state_e state_n;

  logic [idx_width_lp-1:0] cnt_r;
  logic                    phase_r;
  logic [idx_width_lp-1:0] last_idx;
  logic                    last_elem;
  logic                    load_resp;
  logic [addr_width_p-1:0] base_addr;
  logic [addr_width_p-1:0] elem_off;

  // counts of 1 to 8 only, so len-1 fits the index
  assign last_idx  = idx_width_lp'(len_i - 1'b1);
  assign last_elem = (cnt_r == last_idx);
  assign load_resp = (state_r == LOAD_WAIT) && mem_resp_v_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      IDLE: begin
        if (start_i) begin
          state_n = LOAD_REQ;
        end
      end
      LOAD_REQ: begin
        if (mem_req_ready_i) begin
          state_n = LOAD_WAIT;
        end
      end
      LOAD_WAIT: begin
        if (mem_resp_v_i) begin
          state_n = (last_elem && phase_r) ? STORE_REQ : LOAD_REQ;
        end
      end
      STORE_REQ: begin
        if (mem_req_ready_i) begin
          state_n = STORE_WAIT;
        end
      end
      STORE_WAIT: begin
        if (mem_resp_v_i) begin
          state_n = FINISH;
        end
      end
      FINISH: begin
        state_n = IDLE;
      end
      default: begin
        state_n = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  // phase 0 walks A, phase 1 walks B
  always_ff @(posedge clk_i) begin
    if (reset_i || (state_r == IDLE)) begin
      cnt_r   <= '0;
      phase_r <= 1'b0;
    end else if (load_resp) begin
      if (last_elem) begin
        cnt_r   <= '0;
        phase_r <= 1'b1;
      end else begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  assign base_addr = phase_r ? b_ptr_i[addr_width_p-1:0] : a_ptr_i[addr_width_p-1:0];
  assign elem_off  = addr_width_p'(cnt_r) * addr_width_p'(elem_bytes_c);

  assign mem_req_v_o    = (state_r == LOAD_REQ) || (state_r == STORE_REQ);
  assign mem_req_we_o   = (state_r == STORE_REQ);
  assign mem_req_addr_o = (state_r == STORE_REQ) ? res_ptr_i[addr_width_p-1:0]
                                                 : base_addr + elem_off;
  // operands stay frozen until the next start, so the sum holds while the store waits
  assign mem_req_wdata_o = dot_i;

  assign clear_o     = (state_r == IDLE) && start_i;
  assign wr_a_o      = load_resp && !phase_r;
  assign wr_b_o      = load_resp && phase_r;
  assign idx_o       = cnt_r;
  assign load_data_o = mem_resp_data_i;

  assign idle_o = (state_r == IDLE);
  assign done_o = (state_r == FINISH);

endmodule

/* rtl/vdp_dot_unit.sv */
`timescale 1ns/1ps

module vdp_dot_unit #(
  parameter int data_width_p = vdp_pkg::data_width_c
  , parameter int max_len_p  = vdp_pkg::max_len_c
) (
  input  logic                           clk_i
  , input  logic                         reset_i

  , input  logic                         clear_i
  , input  logic                         wr_a_i
  , input  logic                         wr_b_i
  , input  logic [$clog2(max_len_p)-1:0] idx_i
  , input  logic [data_width_p-1:0]      data_i

  , output logic [data_width_p-1:0]      dot_o
);

  logic [data_width_p-1:0] a_r [max_len_p];
  logic [data_width_p-1:0] b_r [max_len_p];

  // heap ordered tree with leaves at max_len_p and up and the root at 1
  logic [data_width_p-1:0] node [1:2*max_len_p-1];

  // cleared slots hold zero so short vectors add nothing
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      for (int i = 0; i < max_len_p; i++) begin
        a_r[i] <= '0;
        b_r[i] <= '0;
      end
    end else begin
      if (wr_a_i) begin
        a_r[idx_i] <= data_i;
      end
      if (wr_b_i) begin
        b_r[idx_i] <= data_i;
      end
    end
  end

  // products keep the low data_width_p bits
  for (genvar i = 0; i < max_len_p; i++) begin : g_prod
    assign node[max_len_p+i] = a_r[i] * b_r[i];
  end

  // each inner node sums its two children over log2(max_len_p) levels
  for (genvar n = 1; n < max_len_p; n++) begin : g_sum
    assign node[n] = node[2*n] + node[2*n+1];
  end

  assign dot_o = node[1];

endmodule

/* rtl/vdp_top.sv */
`timescale 1ns/1ps

module vdp_top #(
  parameter int data_width_p = vdp_pkg::data_width_c
  , parameter int addr_width_p = vdp_pkg::addr_width_c
  , parameter int max_len_p    = vdp_pkg::max_len_c
) (
  input  logic                                  clk_i
  , input  logic                                reset_i

  // register port
  , input  logic                                csr_v_i
  , input  logic                                csr_we_i
  , input  logic [vdp_pkg::csr_addr_width_c-1:0] csr_addr_i
  , input  logic [vdp_pkg::data_width_c-1:0]     csr_wdata_i
  , output logic                                csr_resp_v_o
  , output logic [vdp_pkg::data_width_c-1:0]     csr_rdata_o

  // memory port
  , output logic                                mem_req_v_o
  , output logic                                mem_req_we_o
  , output logic [addr_width_p-1:0]             mem_req_addr_o
  , output logic [data_width_p-1:0]             mem_req_wdata_o
  , input  logic                                mem_req_ready_i
  , input  logic                                mem_resp_v_i
  , input  logic [data_width_p-1:0]             mem_resp_data_i
);

  import vdp_pkg::*;

  logic                         start;
  logic [data_width_c-1:0]      a_ptr;
  logic [data_width_c-1:0]      b_ptr;
  logic [data_width_c-1:0]      len;
  logic [data_width_c-1:0]      res_ptr;
  logic                         idle;
  logic                         done;
  logic                         clear;
  logic                         wr_a;
  logic                         wr_b;
  logic [$clog2(max_len_p)-1:0] idx;
  logic [data_width_p-1:0]      load_data;
  logic [data_width_p-1:0]      dot;

  vdp_csr i_csr (
    .clk_i         (clk_i)
    , .reset_i     (reset_i)
    , .csr_v_i     (csr_v_i)
    , .csr_we_i    (csr_we_i)
    , .csr_addr_i  (csr_addr_i)
    , .csr_wdata_i (csr_wdata_i)
    , .idle_i      (idle)
    , .done_i      (done)
    , .csr_resp_v_o(csr_resp_v_o)
    , .csr_rdata_o (csr_rdata_o)
    , .start_o     (start)
    , .a_ptr_o     (a_ptr)
    , .b_ptr_o     (b_ptr)
    , .len_o       (len)
    , .res_ptr_o   (res_ptr)
  );

  vdp_sequencer #(
    .data_width_p  (data_width_p)
    , .addr_width_p(addr_width_p)
    , .max_len_p   (max_len_p)
  ) i_seq (
    .clk_i            (clk_i)
    , .reset_i        (reset_i)
    , .start_i        (start)
    , .a_ptr_i        (a_ptr)
    , .b_ptr_i        (b_ptr)
    , .len_i          (len)
    , .res_ptr_i      (res_ptr)
    , .dot_i          (dot)
    , .idle_o         (idle)
    , .done_o         (done)
    , .clear_o        (clear)
    , .wr_a_o         (wr_a)
    , .wr_b_o         (wr_b)
    , .idx_o          (idx)
    , .load_data_o    (load_data)
    , .mem_req_v_o    (mem_req_v_o)
    , .mem_req_we_o   (mem_req_we_o)
    , .mem_req_addr_o (mem_req_addr_o)
    , .mem_req_wdata_o(mem_req_wdata_o)
    , .mem_req_ready_i(mem_req_ready_i)
    , .mem_resp_v_i   (mem_resp_v_i)
    , .mem_resp_data_i(mem_resp_data_i)
  );

  vdp_dot_unit #(
    .data_width_p(data_width_p)
    , .max_len_p (max_len_p)
  ) i_dot (
    .clk_i    (clk_i)
    , .reset_i(reset_i)
    , .clear_i(clear)
    , .wr_a_i (wr_a)
    , .wr_b_i (wr_b)
    , .idx_i  (idx)
    , .data_i (load_data)
    , .dot_o  (dot)
  );

endmodule

/* dv/vdp_properties.sv */
`timescale 1ns/1ps

module vdp_properties #(
  parameter int data_width_p = vdp_pkg::data_width_c
  , parameter int addr_width_p = vdp_pkg::addr_width_c
) (
  input  logic                      clk_i
  , input  logic                    reset_i
  , input  logic                    csr_v_i
  , input  logic                    csr_resp_v_o
  , input  logic                    mem_req_v_o
  , input  logic                    mem_req_we_o
  , input  logic [addr_width_p-1:0] mem_req_addr_o
  , input  logic [data_width_p-1:0] mem_req_wdata_o
  , input  logic                    mem_req_ready_i
  , input  logic                    mem_resp_v_i
);

  logic outstanding_r;

  // set when a request is taken, cleared by its response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_r <= 1'b0;
    end else if (mem_req_v_o && mem_req_ready_i) begin
      outstanding_r <= 1'b1;
    end else if (mem_resp_v_i) begin
      outstanding_r <= 1'b0;
    end
  end

  req_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_v_o && !mem_req_ready_i |=> mem_req_v_o && $stable(mem_req_we_o)
      && $stable(mem_req_addr_o) && $stable(mem_req_wdata_o))
    else $error("memory request changed before it was taken");

  csr_resp_a: assert property (@(posedge clk_i) disable iff (reset_i)
    csr_v_i |=> csr_resp_v_o)
    else $error("register command got no response one cycle later");

  csr_no_resp_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !csr_v_i |=> !csr_resp_v_o)
    else $error("register response without a command");

  single_req_a: assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding_r |-> !mem_req_v_o)
    else $error("new memory request while one is outstanding");

endmodule

bind vdp_top vdp_properties #(
  .data_width_p  (data_width_p)
  , .addr_width_p(addr_width_p)
) i_props (
  .clk_i            (clk_i)
  , .reset_i        (reset_i)
  , .csr_v_i        (csr_v_i)
  , .csr_resp_v_o   (csr_resp_v_o)
  , .mem_req_v_o    (mem_req_v_o)
  , .mem_req_we_o   (mem_req_we_o)
  , .mem_req_addr_o (mem_req_addr_o)
  , .mem_req_wdata_o(mem_req_wdata_o)
  , .mem_req_ready_i(mem_req_ready_i)
  , .mem_resp_v_i   (mem_resp_v_i)
);

/* dv/vdp_tb.sv */
`timescale 1ns/1ps

module vdp_tb;

  import vdp_pkg::*;

  localparam int unsigned seed_c = 32'hb553_d39d;
  localparam int resp_limit_c = 20;
  localparam int poll_limit_c = 1000;
  localparam int num_jobs_c = 20;

  logic                        clk_i;
  logic                        reset_i;
  logic                        csr_v_i;
  logic                        csr_we_i;
  logic [csr_addr_width_c-1:0] csr_addr_i;
  logic [data_width_c-1:0]     csr_wdata_i;
  logic                        csr_resp_v_o;
  logic [data_width_c-1:0]     csr_rdata_o;
  logic                        mem_req_v_o;
  logic                        mem_req_we_o;
  logic [addr_width_c-1:0]     mem_req_addr_o;
  logic [data_width_c-1:0]     mem_req_wdata_o;
  logic                        mem_req_ready_i;
  logic                        mem_resp_v_i;
  logic [data_width_c-1:0]     mem_resp_data_i;

  // sparse backing store plus a log of every request the memory took
  logic [data_width_c-1:0] mem [logic [addr_width_c-1:0]];
  logic                    log_we [$];
  logic [addr_width_c-1:0] log_addr [$];
  logic [data_width_c-1:0] log_data [$];
  int                      ready_pct;

  vdp_top #(
    .data_width_p  (data_width_c)
    , .addr_width_p(addr_width_c)
    , .max_len_p   (max_len_c)
  ) i_dut (
    .clk_i            (clk_i)
    , .reset_i        (reset_i)
    , .csr_v_i        (csr_v_i)
    , .csr_we_i       (csr_we_i)
    , .csr_addr_i     (csr_addr_i)
    , .csr_wdata_i    (csr_wdata_i)
    , .csr_resp_v_o   (csr_resp_v_o)
    , .csr_rdata_o    (csr_rdata_o)
    , .mem_req_v_o    (mem_req_v_o)
    , .mem_req_we_o   (mem_req_we_o)
    , .mem_req_addr_o (mem_req_addr_o)
    , .mem_req_wdata_o(mem_req_wdata_o)
    , .mem_req_ready_i(mem_req_ready_i)
    , .mem_resp_v_i   (mem_resp_v_i)
    , .mem_resp_data_i(mem_resp_data_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR: timed out waiting for %s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on timeout");
  endtask

  function automatic logic [63:0] read_word(input logic [addr_width_c-1:0] addr);
    return mem.exists(addr) ? mem[addr] : 64'd0;
  endfunction

  // sampled mid cycle, a request seen here is taken at the coming edge
  task automatic serve_memory();
    logic                    taken;
    logic                    pending;
    int                      delay_cnt;
    logic [data_width_c-1:0] resp_data;
    pending = 1'b0;
    delay_cnt = 0;
    resp_data = '0;
    forever begin
      @(negedge clk_i);
      taken = mem_req_v_o && mem_req_ready_i && !reset_i;
      if (taken) begin
        log_we.push_back(mem_req_we_o);
        log_addr.push_back(mem_req_addr_o);
        log_data.push_back(mem_req_wdata_o);
        resp_data = mem_req_we_o ? 64'd0 : read_word(mem_req_addr_o);
        if (mem_req_we_o) begin
          mem[mem_req_addr_o] = mem_req_wdata_o;
        end
      end
      @(posedge clk_i);
      #1;
      if (taken) begin
        pending = 1'b1;
        delay_cnt = $urandom_range(0, 4);
      end
      mem_resp_v_i = 1'b0;
      if (pending) begin
        if (delay_cnt == 0) begin
          mem_resp_v_i = 1'b1;
          mem_resp_data_i = resp_data;
          pending = 1'b0;
        end else begin
          delay_cnt--;
        end
      end
      mem_req_ready_i = ($urandom_range(0, 99) < ready_pct);
    end
  endtask

  task automatic wait_csr_resp();
    int cycles;
    cycles = 0;
    while (csr_resp_v_o !== 1'b1) begin
      if (cycles >= resp_limit_c) begin
        report_timeout("register response");
      end
      @(posedge clk_i);
      #1;
      cycles++;
    end
  endtask

  task automatic csr_access(input logic we, input logic [csr_addr_width_c-1:0] addr,
                            input logic [63:0] wdata, output logic [63:0] rdata);
    @(posedge clk_i);
    #1;
    csr_v_i = 1'b1;
    csr_we_i = we;
    csr_addr_i = addr;
    csr_wdata_i = wdata;
    @(posedge clk_i);
    #1;
    csr_v_i = 1'b0;
    csr_we_i = 1'b0;
    wait_csr_resp();
    rdata = csr_rdata_o;
  endtask

  task automatic csr_write(input logic [csr_addr_width_c-1:0] addr, input logic [63:0] data);
    logic [63:0] unused_rd;
    csr_access(1'b1, addr, data, unused_rd);
  endtask

  task automatic csr_read(input logic [csr_addr_width_c-1:0] addr, output logic [63:0] data);
    csr_access(1'b0, addr, 64'd0, data);
  endtask

  task automatic check_readback(input logic [csr_addr_width_c-1:0] idx, input string name);
    logic [63:0] wval;
    logic [63:0] rval;
    wval = {$urandom, $urandom};
    csr_write(idx, wval);
    csr_read(idx, rval);
    check_value(name, wval, rval);
  endtask

  task automatic wait_idle(input string name);
    logic [63:0] status;
    int          polls;
    polls = 0;
    csr_read(csr_status_c, status);
    while (status !== 64'd1) begin
      if (polls >= poll_limit_c) begin
        report_timeout({name, " to return to idle"});
      end
      polls++;
      csr_read(csr_status_c, status);
    end
  endtask

  task automatic run_job(input int job);
    int                      len;
    logic [addr_width_c-1:0] a_ptr;
    logic [addr_width_c-1:0] b_ptr;
    logic [addr_width_c-1:0] res_ptr;
    logic [63:0]             a_val;
    logic [63:0]             b_val;
    logic [63:0]             expected;
    logic [63:0]             rd;
    string                   name;
    len = $urandom_range(1, 8);
    // A, B and the result live in separate regions so they never overlap
    a_ptr = 32'h1000_0000 + 32'($urandom_range(0, 1023)) * 32'd64;
    b_ptr = 32'h2000_0000 + 32'($urandom_range(0, 1023)) * 32'd64;
    res_ptr = 32'h3000_0000 + 32'($urandom_range(0, 1023)) * 32'd8;
    name = $sformatf("job %0d len %0d", job, len);
    expected = '0;
    for (int i = 0; i < len; i++) begin
      a_val = {$urandom, $urandom};
      b_val = {$urandom, $urandom};
      mem[a_ptr + 32'(8 * i)] = a_val;
      mem[b_ptr + 32'(8 * i)] = b_val;
      expected = expected + a_val * b_val;
    end
    mem[res_ptr] = {$urandom, $urandom};
    log_we.delete();
    log_addr.delete();
    log_data.delete();
    csr_write(csr_a_ptr_c, 64'(a_ptr));
    csr_write(csr_b_ptr_c, 64'(b_ptr));
    csr_write(csr_len_c, 64'(len));
    csr_write(csr_res_ptr_c, 64'(res_ptr));
    csr_write(csr_start_c, 64'd1);
    wait_idle(name);
    check_value({name, " request count"}, 64'(2 * len + 1), 64'(log_addr.size()));
    for (int i = 0; i < len; i++) begin
      check_value({name, " A load is a read"}, 64'd0, 64'(log_we[i]));
      check_value({name, " A load address"}, 64'(a_ptr + 32'(8 * i)), 64'(log_addr[i]));
      check_value({name, " B load is a read"}, 64'd0, 64'(log_we[len + i]));
      check_value({name, " B load address"}, 64'(b_ptr + 32'(8 * i)),
                  64'(log_addr[len + i]));
    end
    check_value({name, " store is a write"}, 64'd1, 64'(log_we[2 * len]));
    check_value({name, " store address"}, 64'(res_ptr), 64'(log_addr[2 * len]));
    check_value({name, " store data"}, expected, log_data[2 * len]);
    check_value({name, " result in memory"}, expected, read_word(res_ptr));
    csr_read(csr_a_ptr_c, rd);
    check_value({name, " a_ptr cleared"}, 64'd0, rd);
    csr_read(csr_b_ptr_c, rd);
    check_value({name, " b_ptr cleared"}, 64'd0, rd);
    csr_read(csr_len_c, rd);
    check_value({name, " len cleared"}, 64'd0, rd);
    csr_read(csr_res_ptr_c, rd);
    check_value({name, " res_ptr cleared"}, 64'd0, rd);
    csr_read(csr_start_c, rd);
    check_value({name, " start cleared"}, 64'd0, rd);
  endtask

  initial begin : stimulus
    logic [63:0] rd;
    void'($urandom(seed_c));
    reset_i = 1'b1;
    csr_v_i = 1'b0;
    csr_we_i = 1'b0;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    mem_req_ready_i = 1'b0;
    mem_resp_v_i = 1'b0;
    mem_resp_data_i = '0;
    ready_pct = 90;
    fork
      serve_memory();
    join_none
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    csr_read(csr_status_c, rd);
    check_value("status after reset", 64'd1, rd);
    csr_read(csr_start_c, rd);
    check_value("start after reset", 64'd0, rd);

    for (int r = 0; r < 4; r++) begin
      check_readback(csr_a_ptr_c, "a_ptr readback");
      check_readback(csr_b_ptr_c, "b_ptr readback");
      check_readback(csr_len_c, "len readback");
      check_readback(csr_res_ptr_c, "res_ptr readback");
    end
    csr_write(3'd7, 64'hdead_beef_0bad_f00d);
    csr_read(3'd7, rd);
    check_value("unknown index reads zero", 64'd0, rd);

    // second half runs under heavy back-pressure
    for (int j = 0; j < num_jobs_c; j++) begin
      ready_pct = (j < num_jobs_c / 2) ? 90 : 30;
      run_job(j);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* vdp.f */
rtl/vdp_pkg.sv
rtl/vdp_csr.sv
rtl/vdp_sequencer.sv
rtl/vdp_dot_unit.sv
rtl/vdp_top.sv
dv/vdp_properties.sv
dv/vdp_tb.sv

/* Makefile */
TOP = vdp_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vdp.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
